//--- run_sim.sh
#!/bin/sh
# build and run the current steering DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_current_steering_dac
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir obj_dir -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

exit 0

//--- src/current_steering_dac.sv
`default_nettype none

module current_steering_dac (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  dac_pkg::dac_code_t code,
    input  logic               pdb,
    output logic               out_valid,
    output dac_pkg::current_t  iout,
    output dac_pkg::current_t  ioutb,
    output dac_pkg::current_t  ical,
    output logic               ical_valid
);
    import dac_pkg::*;

    steer_t steer;   // stage 1 to stage 2
    sum_t   sum;     // stage 2 to stage 3

    steering_decoder u_decoder (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .code     (code),
        .steer    (steer)
    );

    current_summer u_summer (
        .clk   (clk),
        .reset (reset),
        .steer (steer),
        .sum   (sum)
    );

    output_stage u_output (
        .clk        (clk),
        .reset      (reset),
        .pdb        (pdb),
        .sum        (sum),
        .out_valid  (out_valid),
        .iout       (iout),
        .ioutb      (ioutb),
        .ical       (ical),
        .ical_valid (ical_valid)
    );

endmodule

`default_nettype wire

//--- src/current_summer.sv
`default_nettype none

module current_summer (
    input  logic            clk,
    input  logic            reset,
    input  dac_pkg::steer_t steer,
    output dac_pkg::sum_t   sum
);
    import dac_pkg::*;

    sum_t     sum_d;
    current_t pos_acc;
    current_t neg_acc;
    current_t cal_w;     // weight of the claimed main cell
    logic     cal_hit;

    always_comb begin
        pos_acc = '0;
        neg_acc = '0;
        cal_w   = '0;
        cal_hit = 1'b0;
        for (int k = 0; k < BIN_CELLS; k++) begin
            case (steer.bin_state[k])
                CELL_POS: pos_acc = pos_acc + current_t'(1 << k);
                CELL_NEG: neg_acc = neg_acc + current_t'(1 << k);
                CELL_CAL: begin
                    cal_w   = current_t'(1 << k);
                    cal_hit = 1'b1;
                end
                default: ;   // parked cell adds nothing
            endcase
        end
        for (int t = 0; t < THERM_CELLS; t++) begin
            case (steer.therm_state[t])
                CELL_POS: pos_acc = pos_acc + current_t'(THERM_UNITS);
                CELL_NEG: neg_acc = neg_acc + current_t'(THERM_UNITS);
                CELL_CAL: begin
                    cal_w   = current_t'(THERM_UNITS);
                    cal_hit = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        sum_d            = '0;
        sum_d.valid      = steer.valid;
        sum_d.iout       = pos_acc;
        sum_d.ioutb      = neg_acc;
        sum_d.ical_valid = steer.valid && (steer.cal_red || cal_hit);
        if (steer.cal_red)
            sum_d.ical = current_t'(1);   // redundant cell is one lsb
        else if (cal_hit)
            sum_d.ical = cal_w;
    end

    always_ff @(posedge clk) begin
        sum <= sum_d;
        if (reset) begin
            sum.valid      <= 1'b0;
            sum.ical_valid <= 1'b0;
        end
    end

    // parked and claimed cells only ever remove current
    a_full_scale: assert property (@(posedge clk) disable iff (reset)
        sum.valid |-> (32'(sum.iout) + 32'(sum.ioutb) <= FULL_SCALE));

    // a select in the active range always yields a calibration current one cycle on
    a_cal_select: assert property (@(posedge clk) disable iff (reset)
        steer.valid && steer.cal_sel != cal_sel_t'(CAL_NONE)
        && 32'(steer.cal_sel) < CAL_THERM_BASE + THERM_CELLS |=> sum.ical_valid);

endmodule

`default_nettype wire

//--- src/dac_pkg.sv
`default_nettype none

package dac_pkg;

    // cell counts fixed by the code format
    localparam int BIN_CELLS   = 6;
    localparam int THERM_CELLS = 15;     // two spare cells are not modelled
    localparam int THERM_UNITS = 64;     // one thermometer cell in lsb units
    localparam int FULL_SCALE  = 1023;   // 63 binary + 15 * 64 thermometer

    // calibration select encoding
    localparam int CAL_NONE       = 0;
    localparam int CAL_RED        = 1;   // redundant lsb cell, also claims binary cell 0
    localparam int CAL_BIN_BASE   = 2;   // binary cell 1
    localparam int CAL_THERM_BASE = 7;   // thermometer cell 0

    typedef logic [10:0]            current_t;   // current in lsb units
    typedef logic [4:0]             cal_sel_t;
    typedef logic [BIN_CELLS-1:0]   bin_code_t;
    typedef logic [THERM_CELLS-1:0] therm_code_t;

    // where a cell sends its current
    typedef enum logic [1:0] {
        CELL_OFF,   // equal control bits
        CELL_POS,   // steered to iout
        CELL_NEG,   // steered to ioutb
        CELL_CAL    // claimed for calibration, goes to ical only
    } cell_state_e;

    typedef struct packed {
        bin_code_t   datain;
        bin_code_t   datainb;
        therm_code_t datatherm;
        therm_code_t datathermb;
        cal_sel_t    dataical;
    } dac_code_t;

    // decoder to summer
    typedef struct packed {
        logic                           valid;
        cell_state_e [BIN_CELLS-1:0]    bin_state;
        cell_state_e [THERM_CELLS-1:0]  therm_state;
        logic                           cal_red;    // redundant cell feeds ical
        cal_sel_t                       cal_sel;
    } steer_t;

    // summer to output stage
    typedef struct packed {
        logic     valid;
        current_t iout;
        current_t ioutb;
        current_t ical;
        logic     ical_valid;
    } sum_t;

endpackage

`default_nettype wire

//--- src/output_stage.sv
`default_nettype none

module output_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              pdb,
    input  dac_pkg::sum_t     sum,
    output logic              out_valid,
    output dac_pkg::current_t iout,
    output dac_pkg::current_t ioutb,
    output dac_pkg::current_t ical,
    output logic              ical_valid
);
    import dac_pkg::*;

    logic live;   // powered item in this slot

    assign live = pdb && sum.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            iout       <= '0;
            ioutb      <= '0;
            ical       <= '0;
            ical_valid <= 1'b0;
        end else begin
            out_valid  <= sum.valid;            // timing ignores power-down
            ical_valid <= pdb && sum.ical_valid;
            if (live) begin
                iout  <= sum.iout;
                ioutb <= sum.ioutb;
                ical  <= sum.ical;
            end else begin
                // powered down or empty slot sources nothing
                iout  <= '0;
                ioutb <= '0;
                ical  <= '0;
            end
        end
    end

    // the summer only flags calibration on a live pipeline item
    a_ical_in_slot: assert property (@(posedge clk) disable iff (reset)
        ical_valid |-> out_valid);

endmodule

`default_nettype wire

//--- src/steering_decoder.sv
`default_nettype none

module steering_decoder (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  dac_pkg::dac_code_t code,
    output dac_pkg::steer_t   steer
);
    import dac_pkg::*;

    steer_t                             steer_d;
    logic [BIN_CELLS+THERM_CELLS-1:0]   cal_flags;   // one bit per cell in CELL_CAL

    function automatic cell_state_e classify(input logic t, input logic c, input logic claimed);
        if (claimed)
            return CELL_CAL;
        else if (t && !c)
            return CELL_POS;
        else if (!t && c)
            return CELL_NEG;
        else
            return CELL_OFF;   // both bits equal, cell is parked
    endfunction

    always_comb begin
        steer_d         = '0;
        steer_d.valid   = in_valid;
        steer_d.cal_sel = code.dataical;
        steer_d.cal_red = (code.dataical == cal_sel_t'(CAL_RED));
        // binary cell 0 goes with the redundant cell
        steer_d.bin_state[0] = classify(code.datain[0], code.datainb[0], steer_d.cal_red);
        for (int k = 1; k < BIN_CELLS; k++) begin
            steer_d.bin_state[k] = classify(code.datain[k], code.datainb[k],
                code.dataical == cal_sel_t'(CAL_BIN_BASE + k - 1));
        end
        for (int t = 0; t < THERM_CELLS; t++) begin
            steer_d.therm_state[t] = classify(code.datatherm[t], code.datathermb[t],
                code.dataical == cal_sel_t'(CAL_THERM_BASE + t));
        end
    end

    always_ff @(posedge clk) begin
        steer <= steer_d;   // payload loads every cycle
        if (reset) begin
            steer.valid <= 1'b0;
        end
    end

    always_comb begin
        for (int k = 0; k < BIN_CELLS; k++) begin
            cal_flags[k] = (steer.bin_state[k] == CELL_CAL);
        end
        for (int t = 0; t < THERM_CELLS; t++) begin
            cal_flags[BIN_CELLS+t] = (steer.therm_state[t] == CELL_CAL);
        end
    end

    // a single calibration select can never claim two cells
    a_one_cal_cell: assert property (@(posedge clk) disable iff (reset)
        in_valid |=> $onehot0(cal_flags));

endmodule

`default_nettype wire

//--- verification/dac_ref_model.svh
`ifndef DAC_REF_MODEL_SVH
`define DAC_REF_MODEL_SVH

// expected outputs for one code word
typedef struct packed {
    current_t iout;
    current_t ioutb;
    current_t ical;
    logic     ical_valid;
} expect_t;

function automatic expect_t dac_ref_model(input dac_code_t c, input logic pdb);
    expect_t e;
    int      sel;
    int      pos;
    int      neg;
    int      cal;
    bit      claimed;
    sel = int'(c.dataical);
    pos = 0;
    neg = 0;
    cal = 0;
    for (int k = 0; k < BIN_CELLS; k++) begin
        // select 1 takes cell 0 along with the redundant cell, 2..6 take cells 1..5
        claimed = (k == 0) ? (sel == 1) : (sel == k + 1);
        if (claimed)
            cal = (k == 0) ? 1 : 2 ** k;   // redundant cell is one unit
        else if (c.datain[k] && !c.datainb[k])
            pos += 2 ** k;
        else if (!c.datain[k] && c.datainb[k])
            neg += 2 ** k;
    end
    for (int t = 0; t < THERM_CELLS; t++) begin
        if (sel == 7 + t)
            cal = 64;
        else if (c.datatherm[t] && !c.datathermb[t])
            pos += 64;
        else if (!c.datatherm[t] && c.datathermb[t])
            neg += 64;
    end
    e.iout       = current_t'(pos);
    e.ioutb      = current_t'(neg);
    e.ical       = current_t'(cal);
    e.ical_valid = (sel >= 1) && (sel <= 21);   // 0 and 22..31 select no cell
    if (!pdb)
        e = '0;   // powered down
    return e;
endfunction

`endif

//--- verification/tb_current_steering_dac.sv
`default_nettype none

module tb_current_steering_dac;
    import dac_pkg::*;

    `include "dac_ref_model.svh"

    localparam int DRAIN_LIMIT = 64;   // cycles allowed for the pipeline to empty

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    dac_code_t code;
    logic      pdb;
    logic      out_valid;
    current_t  iout;
    current_t  ioutb;
    current_t  ical;
    logic      ical_valid;

    expect_t exp_q[$];
    int      edge_q[$];        // edge at which each item must leave
    int      cycle_cnt = 0;    // posedges seen so far
    int      err_cnt = 0;
    int      item_cnt = 0;
    int      test_cnt = 0;
    int      failed_tests = 0;
    int      test_errs_start;
    int      test_items_start;

    current_steering_dac u_dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .code       (code),
        .pdb        (pdb),
        .out_valid  (out_valid),
        .iout       (iout),
        .ioutb      (ioutb),
        .ical       (ical),
        .ical_valid (ical_valid)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    task automatic report_mismatch(input string name, input current_t got, input current_t want);
        $display("Fail %s: got 0x%0h expected 0x%0h", name, got, want);
        err_cnt++;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // outputs are read on the falling edge, half a cycle after they change
    always @(negedge clk) begin : compare
        expect_t e;
        int      due;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid high with no code in flight at edge %0d", cycle_cnt);
                err_cnt++;
            end else begin
                e   = exp_q.pop_front();
                due = edge_q.pop_front();
                item_cnt++;
                if (cycle_cnt != due) begin
                    $display("code left the pipeline at edge %0d instead of edge %0d",
                        cycle_cnt, due);
                    err_cnt++;
                end
                if (iout !== e.iout)
                    report_mismatch("iout", iout, e.iout);
                if (ioutb !== e.ioutb)
                    report_mismatch("ioutb", ioutb, e.ioutb);
                if (ical !== e.ical)
                    report_mismatch("ical", ical, e.ical);
                if (ical_valid !== e.ical_valid)
                    report_mismatch("ical_valid", current_t'(ical_valid), current_t'(e.ical_valid));
            end
        end else if (!reset && ical_valid) begin
            $display("ical_valid high while out_valid is low at edge %0d", cycle_cnt);
            err_cnt++;
        end
    end

    function automatic dac_code_t random_code(input bit complementary, input int sel);
        dac_code_t c;
        c.datain    = bin_code_t'($urandom());
        c.datatherm = therm_code_t'($urandom());
        if (complementary) begin
            c.datainb    = ~c.datain;
            c.datathermb = ~c.datatherm;
        end else begin
            c.datainb    = bin_code_t'($urandom());   // some pairs end up equal
            c.datathermb = therm_code_t'($urandom());
        end
        c.dataical = cal_sel_t'(sel);
        return c;
    endfunction

    task automatic send_code(input dac_code_t c);
        @(negedge clk);
        in_valid = 1'b1;
        code     = c;
        exp_q.push_back(dac_ref_model(c, pdb));
        edge_q.push_back(cycle_cnt + 3);   // result leaves on the third rising edge from here
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_valid = 1'b0;
            code     = random_code(1'b0, 0);   // junk on the bus must be ignored
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            in_valid = 1'b0;
            waited++;
        end
        if (exp_q.size() != 0)
            abort_run("timeout: the pipeline did not return every code");
    endtask

    task automatic check_idle_outputs();
        if (out_valid !== 1'b0 || ical_valid !== 1'b0) begin
            $display("a valid output is high after reset with no code sent");
            err_cnt++;
        end
        if (iout !== '0)
            report_mismatch("iout", iout, '0);
        if (ioutb !== '0)
            report_mismatch("ioutb", ioutb, '0);
        if (ical !== '0)
            report_mismatch("ical", ical, '0);
    endtask

    task automatic start_test();
        test_cnt++;
        test_errs_start  = err_cnt;
        test_items_start = item_cnt;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_cnt - test_errs_start;
        if (errs != 0)
            failed_tests++;
        $display("test %0d %s: %0d codes, %0d errors, %s", test_cnt, name,
            item_cnt - test_items_start, errs, (errs == 0) ? "ok" : "failed");
    endtask

    initial begin
        void'($urandom(22));
        reset    = 1'b1;
        in_valid = 1'b0;
        code     = '0;
        pdb      = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        start_test();
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        finish_test("idle after reset");

        start_test();
        repeat (40) send_code(random_code(1'b1, CAL_NONE));
        wait_drain();
        finish_test("complementary codes");

        start_test();
        repeat (40) send_code(random_code(1'b0, CAL_NONE));
        wait_drain();
        finish_test("equal control pairs");

        start_test();
        for (int s = 0; s < 32; s++)
            send_code(random_code(1'b1, s));
        for (int s = 0; s < 32; s++)
            send_code(random_code(1'b0, s));
        wait_drain();
        finish_test("calibration select sweep");

        start_test();
        pdb = 1'b0;   // pipeline is empty, so every item sees pdb low
        repeat (16) send_code(random_code(1'b0, int'($urandom_range(31, 0))));
        wait_drain();
        pdb = 1'b1;
        repeat (16) send_code(random_code(1'b0, int'($urandom_range(31, 0))));
        wait_drain();
        finish_test("power down");

        start_test();
        repeat (6) begin
            send_code(random_code(1'b1, int'($urandom_range(31, 0))));
            wait_drain();
        end
        repeat (30) begin
            send_code(random_code(1'b0, int'($urandom_range(31, 0))));
            if ($urandom_range(3, 0) == 0)
                idle(int'($urandom_range(3, 1)));
        end
        wait_drain();
        finish_test("latency of three edges");

        $display("tests %0d, failed tests %0d, codes checked %0d, errors %0d",
            test_cnt, failed_tests, item_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
src/dac_pkg.sv
src/steering_decoder.sv
src/current_summer.sv
src/output_stage.sv
src/current_steering_dac.sv
verification/tb_current_steering_dac.sv
